/* common/imuldiv_pkg.sv */
// shared function codes for the iterative multiply/divide unit
// imported by the request side, the top level and the testbench
`default_nettype none

package imuldiv_pkg;

  // width of the function field on the request port
  localparam int imuldiv_fn_bits = 2;

  // function encoding, signed and unsigned variants of each operation
  typedef enum logic [imuldiv_fn_bits-1:0] {
    fn_mul  = 2'd0,
    fn_mulu = 2'd1,
    fn_div  = 2'd2,
    fn_divu = 2'd3
  } imuldiv_fn_e;

  // true for the two divide functions
  function automatic logic fn_is_div(imuldiv_fn_e fn);
    return (fn == fn_div) || (fn == fn_divu);
  endfunction

  // true when operands are two's complement
  function automatic logic fn_is_signed(imuldiv_fn_e fn);
    return (fn == fn_mul) || (fn == fn_div);
  endfunction

endpackage

`default_nettype wire

/* common/op_if.sv */
// operand and result bus between the request side and the two arithmetic units
// magnitudes are held steady from issue until the response is taken
`timescale 1ns/1ps
`default_nettype none

interface op_if #(
  parameter int width = 32
);

  // issue strobes, one cycle each
  logic                 issue_mul;
  logic                 issue_div;
  // unsigned operand magnitudes
  logic [width-1:0]     a_mag;
  logic [width-1:0]     b_mag;
  // completion strobes and raw results
  logic                 mul_done;
  logic                 div_done;
  logic [2*width-1:0]   product;
  logic [width-1:0]     quotient;
  logic [width-1:0]     remainder;

  modport issuer    (output issue_mul, issue_div, a_mag, b_mag);
  modport mul_unit  (input issue_mul, a_mag, b_mag, output mul_done, product);
  modport div_unit  (input issue_div, a_mag, b_mag, output div_done, quotient, remainder);
  // output side also sees a_mag to rebuild the dividend
  modport collector (input mul_done, div_done, product, quotient, remainder, a_mag);

endinterface

`default_nettype wire

/* common/fix_if.sv */
// sign and special-case flags passed from the request side to the output side
// set on accept, stable until the response is taken
`timescale 1ns/1ps
`default_nettype none

interface fix_if #(
  parameter int width = 32
);

  // divide packing instead of full product
  logic is_div;
  // negate product or quotient
  logic neg_result;
  // negate remainder, dividend was negative
  logic neg_rem;
  // divisor was zero
  logic div_zero;

  modport issuer    (output is_div, neg_result, neg_rem, div_zero);
  modport collector (input is_div, neg_result, neg_rem, div_zero);

endinterface

`default_nettype wire

/* hdl/imuldiv_operand_unpack.sv */
// request side of the multiply/divide unit
// accepts one request while idle, forms operand magnitudes and issues a unit
`timescale 1ns/1ps
`default_nettype none

module imuldiv_operand_unpack #(
  parameter int width = 32
) (
  input  logic                     clk,
  input  logic                     reset,
  input  imuldiv_pkg::imuldiv_fn_e req_fn,
  input  logic [width-1:0]         req_a,
  input  logic [width-1:0]         req_b,
  input  logic                     req_val,
  output logic                     req_rdy,
  input  logic                     resp_taken,
  op_if.issuer                     op,
  fix_if.issuer                    fix
);
  import imuldiv_pkg::*;

  logic             busy;
  logic             accept;
  logic             is_signed;
  logic             sign_a;
  logic             sign_b;
  logic [width-1:0] mag_a;
  logic [width-1:0] mag_b;

  // one operation in flight, ready only when fully idle
  assign req_rdy = !busy;
  assign accept  = req_val && req_rdy;

  // sign bits only count for the signed functions
  assign is_signed = fn_is_signed(req_fn);
  assign sign_a    = is_signed && req_a[width-1];
  assign sign_b    = is_signed && req_b[width-1];
  assign mag_a     = sign_a ? (~req_a + 1'b1) : req_a;
  assign mag_b     = sign_b ? (~req_b + 1'b1) : req_b;

  // ---------------------------------------------------------------------------
  // control: busy flag and issue strobes
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      busy         <= 1'b0;
      op.issue_mul <= 1'b0;
      op.issue_div <= 1'b0;
    end else begin
      // strobe is high for the cycle after the accepting edge
      op.issue_mul <= accept && !fn_is_div(req_fn);
      op.issue_div <= accept && fn_is_div(req_fn);
      if (accept) begin
        busy <= 1'b1;
      end else if (resp_taken) begin
        busy <= 1'b0;
      end
    end
  end

  // operands and flags, held until the next accept
  always_ff @(posedge clk) begin
    if (accept) begin
      op.a_mag       <= mag_a;
      op.b_mag       <= mag_b;
      fix.is_div     <= fn_is_div(req_fn);
      fix.neg_result <= sign_a ^ sign_b;
      // remainder follows the dividend sign, only for signed divide
      fix.neg_rem    <= sign_a && fn_is_div(req_fn);
      fix.div_zero   <= fn_is_div(req_fn) && (req_b == '0);
    end
  end

endmodule

`default_nettype wire

/* imul/imul_ctrl.sv */
// control FSM for the shift-add multiplier
// idle -> calc for width cycles -> done for one cycle, drives the datapath enables
`timescale 1ns/1ps
`default_nettype none

module imul_ctrl #(
  parameter int width = 32
) (
  input  logic  clk,
  input  logic  reset,
  op_if.mul_unit op,
  output logic  a_en,
  output logic  a_shift,
  output logic  b_en,
  output logic  b_shift,
  output logic  acc_en
);

  localparam int cnt_bits = $clog2(width);

  typedef enum logic [1:0] {
    st_idle,
    st_calc,
    st_done
  } state_e;

  state_e              state;
  logic [cnt_bits-1:0] count;
  logic                load;
  logic                calc;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      count <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (op.issue_mul) begin
            state <= st_calc;
            count <= '0;
          end
        end
        st_calc: begin
          // last of width iterations
          if (count == cnt_bits'(width - 1)) begin
            state <= st_done;
          end else begin
            count <= count + 1'b1;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // load on issue, shift-accumulate every calc cycle
  assign load    = (state == st_idle) && op.issue_mul;
  assign calc    = (state == st_calc);
  assign a_en    = load || calc;
  assign a_shift = calc;
  assign b_en    = load || calc;
  assign b_shift = calc;
  assign acc_en  = load || calc;

  // done strobe is the single cycle spent in the done state
  assign op.mul_done = (state == st_done);

endmodule

`default_nettype wire

/* imul/imul_dpath.sv */
// shift-add multiplier datapath on unsigned operand magnitudes
// sign correction happens later on the output side
`timescale 1ns/1ps
`default_nettype none

module imul_dpath #(
  parameter int width = 32
) (
  input  logic  clk,
  input  logic  reset,
  input  logic  a_en,
  input  logic  a_shift,
  input  logic  b_en,
  input  logic  b_shift,
  input  logic  acc_en,
  op_if.mul_unit op
);

  // multiplicand grows left across the full product width
  logic [2*width-1:0] mcand;
  logic [width-1:0]   mplier;
  logic [2*width-1:0] acc;
  logic [2*width-1:0] addend;

  // add the shifted multiplicand when the current multiplier bit is set
  assign addend = mplier[0] ? mcand : '0;

  always_ff @(posedge clk) begin
    if (a_en) begin
      mcand <= a_shift ? (mcand << 1) : {{width{1'b0}}, op.a_mag};
    end
    if (b_en) begin
      mplier <= b_shift ? (mplier >> 1) : op.b_mag;
    end
  end

  // accumulator clears on load, so the first calc cycle needs no special case
  always_ff @(posedge clk) begin
    if (reset) begin
      acc <= '0;
    end else if (acc_en) begin
      acc <= b_shift ? (acc + addend) : '0;
    end
  end

  // unsigned product, valid in the done cycle and held afterwards
  assign op.product = acc;

endmodule

`default_nettype wire

/* idiv/idiv_restoring.sv */
// iterative restoring divider on unsigned magnitudes
// one quotient bit per cycle, width cycles after the issue strobe
`timescale 1ns/1ps
`default_nettype none

module idiv_restoring #(
  parameter int width = 32
) (
  input  logic   clk,
  input  logic   reset,
  op_if.div_unit op
);

  localparam int cnt_bits = $clog2(width);

  typedef enum logic [1:0] {
    st_idle,
    st_calc,
    st_done
  } state_e;

  state_e              state;
  logic [cnt_bits-1:0] count;

  // quotient register starts as the dividend and fills with result bits
  logic [width-1:0]    quot;
  logic [width-1:0]    rem;
  logic [width:0]      rem_shift;
  logic [width+1:0]    diff;
  logic                fits;

  // ---------------------------------------------------------------------------
  // one restoring step
  // ---------------------------------------------------------------------------
  // next dividend bit comes from the top of the quotient register
  assign rem_shift = {rem, quot[width-1]};
  // extra top bit acts as the borrow
  assign diff      = {1'b0, rem_shift} - {2'b00, op.b_mag};
  assign fits      = !diff[width+1];

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      count <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (op.issue_div) begin
            state <= st_calc;
            count <= '0;
          end
        end
        st_calc: begin
          if (count == cnt_bits'(width - 1)) begin
            state <= st_done;
          end else begin
            count <= count + 1'b1;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state == st_idle) && op.issue_div) begin
      quot <= op.a_mag;
      rem  <= '0;
    end else if (state == st_calc) begin
      // keep the difference only when the divisor fits
      // a zero divisor always fits, giving all ones and rem = dividend
      rem  <= fits ? diff[width-1:0] : rem_shift[width-1:0];
      quot <= {quot[width-2:0], fits};
    end
  end

  assign op.div_done  = (state == st_done);
  assign op.quotient  = quot;
  assign op.remainder = rem;

endmodule

`default_nettype wire

/* hdl/imuldiv_resp_pack.sv */
// output side of the multiply/divide unit
// restores result signs, packs {remainder, quotient} and holds it under back-pressure
`timescale 1ns/1ps
`default_nettype none

module imuldiv_resp_pack #(
  parameter int width = 32
) (
  input  logic                 clk,
  input  logic                 reset,
  op_if.collector              op,
  fix_if.collector             fix,
  output logic [2*width-1:0]   resp_result,
  output logic                 resp_val,
  input  logic                 resp_rdy,
  output logic                 resp_taken
);

  logic               load;
  logic [2*width-1:0] prod_fix;
  logic [width-1:0]   quot_fix;
  logic [width-1:0]   rem_fix;
  logic [width-1:0]   dividend;

  // either unit finishing loads the response register
  assign load = op.mul_done || op.div_done;

  assign prod_fix = fix.neg_result ? -op.product : op.product;

  // original dividend, rebuilt from magnitude and sign
  assign dividend = fix.neg_rem ? -op.a_mag : op.a_mag;

  always_comb begin
    if (fix.div_zero) begin
      // divide by zero: all ones quotient, dividend as remainder
      quot_fix = '1;
      rem_fix  = dividend;
    end else begin
      quot_fix = fix.neg_result ? -op.quotient : op.quotient;
      rem_fix  = fix.neg_rem ? -op.remainder : op.remainder;
    end
  end

  // ---------------------------------------------------------------------------
  // response handshake
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      resp_val   <= 1'b0;
      resp_taken <= 1'b0;
    end else begin
      // pulse for one cycle after the transfer edge, frees the request side
      resp_taken <= resp_val && resp_rdy;
      if (load) begin
        resp_val <= 1'b1;
      end else if (resp_rdy) begin
        resp_val <= 1'b0;
      end
    end
  end

  // result held until the next done strobe
  always_ff @(posedge clk) begin
    if (load) begin
      resp_result <= fix.is_div ? {rem_fix, quot_fix} : prod_fix;
    end
  end

endmodule

`default_nettype wire

/* hdl/imuldiv.sv */
// iterative integer multiply/divide unit, top level
// val/rdy request and response ports, one operation in flight
`timescale 1ns/1ps
`default_nettype none

module imuldiv #(
  parameter int width = 32
) (
  input  logic                     clk,
  input  logic                     reset,
  input  imuldiv_pkg::imuldiv_fn_e req_fn,
  input  logic [width-1:0]         req_a,
  input  logic [width-1:0]         req_b,
  input  logic                     req_val,
  output logic                     req_rdy,
  output logic [2*width-1:0]       resp_result,
  output logic                     resp_val,
  input  logic                     resp_rdy
);

  logic resp_taken;
  // multiplier control to datapath
  logic a_en;
  logic a_shift;
  logic b_en;
  logic b_shift;
  logic acc_en;

  op_if  #(.width(width)) op_bus ();
  fix_if #(.width(width)) fix_bus ();

  imuldiv_operand_unpack #(.width(width)) unpack (
    .clk(clk), .reset(reset), .req_fn(req_fn), .req_a(req_a), .req_b(req_b),
    .req_val(req_val), .req_rdy(req_rdy), .resp_taken(resp_taken),
    .op(op_bus.issuer), .fix(fix_bus.issuer)
  );

  imul_ctrl #(.width(width)) mul_ctrl (
    .clk(clk), .reset(reset), .op(op_bus.mul_unit), .a_en(a_en), .a_shift(a_shift),
    .b_en(b_en), .b_shift(b_shift), .acc_en(acc_en)
  );

  imul_dpath #(.width(width)) mul_dpath (
    .clk(clk), .reset(reset), .a_en(a_en), .a_shift(a_shift), .b_en(b_en),
    .b_shift(b_shift), .acc_en(acc_en), .op(op_bus.mul_unit)
  );

  idiv_restoring #(.width(width)) div (
    .clk(clk), .reset(reset), .op(op_bus.div_unit)
  );

  imuldiv_resp_pack #(.width(width)) pack (
    .clk(clk), .reset(reset), .op(op_bus.collector), .fix(fix_bus.collector),
    .resp_result(resp_result), .resp_val(resp_val), .resp_rdy(resp_rdy),
    .resp_taken(resp_taken)
  );

endmodule

`default_nettype wire

/* sim/imuldiv_tb.sv */
// self-checking testbench for the iterative multiply/divide unit
// applies a directed table and random entries and checks value, latency and back-pressure
`timescale 1ns/1ps
`default_nettype none

module imuldiv_tb;
  import imuldiv_pkg::*;

  localparam int width     = 32;
  localparam int n_fixed   = 22;
  localparam int n_random  = 50;
  localparam int n_tests   = n_fixed + n_random;
  localparam int max_stall = 10;
  // accept, width+2 latency, stall and release for every entry plus a reset margin
  localparam int cycle_limit = n_tests * (width + 2 + max_stall + 4) + 200;

  logic               clk;
  logic               reset;
  imuldiv_fn_e        req_fn;
  logic [width-1:0]   req_a;
  logic [width-1:0]   req_b;
  logic               req_val;
  logic               req_rdy;
  logic [2*width-1:0] resp_result;
  logic               resp_val;
  logic               resp_rdy;

  // stimulus and expected values with one row per test
  string              tbl_name [n_tests];
  imuldiv_fn_e        tbl_fn   [n_tests];
  logic [width-1:0]   tbl_a    [n_tests];
  logic [width-1:0]   tbl_b    [n_tests];
  logic [2*width-1:0] tbl_exp  [n_tests];

  int cycles;
  int errors;
  int failed;
  int test_errors;

  imuldiv #(.width(width)) UUT (
    .clk(clk), .reset(reset), .req_fn(req_fn), .req_a(req_a), .req_b(req_b),
    .req_val(req_val), .req_rdy(req_rdy), .resp_result(resp_result),
    .resp_val(resp_val), .resp_rdy(resp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // cycle counter guards against a hung handshake
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display(">>> FAIL");
      $finish;
    end
  end

  // --------------------------------------------------------------------------
  // reference model and table helpers
  // --------------------------------------------------------------------------
  // full product or {remainder, quotient} truncated toward zero
  function automatic logic [2*width-1:0] expected_result(imuldiv_fn_e fn,
      logic [width-1:0] a, logic [width-1:0] b);
    longint             sa;
    longint             sb;
    longint             sq;
    longint             sr;
    logic [2*width-1:0] ua;
    logic [2*width-1:0] ub;
    logic [2*width-1:0] uq;
    logic [2*width-1:0] ur;
    sa = longint'($signed(a));
    sb = longint'($signed(b));
    ua = {{width{1'b0}}, a};
    ub = {{width{1'b0}}, b};
    // zero divisor gives an all ones quotient and the dividend as remainder
    if ((fn == fn_div || fn == fn_divu) && b == '0) begin
      return {a, {width{1'b1}}};
    end
    case (fn)
      fn_mul:  return sa * sb;
      fn_mulu: return ua * ub;
      fn_div: begin
        // min / -1 wraps to min in the low half
        sq = sa / sb;
        sr = sa % sb;
        return {sr[width-1:0], sq[width-1:0]};
      end
      default: begin
        uq = ua / ub;
        ur = ua % ub;
        return {ur[width-1:0], uq[width-1:0]};
      end
    endcase
  endfunction

  function automatic void set_entry(int idx, string name, imuldiv_fn_e fn,
      logic [width-1:0] a, logic [width-1:0] b, logic [2*width-1:0] exp);
    tbl_name[idx] = name;
    tbl_fn[idx]   = fn;
    tbl_a[idx]    = a;
    tbl_b[idx]    = b;
    tbl_exp[idx]  = exp;
  endfunction

  // response must sit still and the request side stay closed
  function automatic void check_held(int idx, logic [2*width-1:0] held);
    assert (resp_val && resp_result === held) else begin
      $display("%s: response changed or dropped while resp_rdy was low", tbl_name[idx]);
      test_errors++;
    end
    assert (!req_rdy) else begin
      $display("%s: req_rdy went high before the response was taken", tbl_name[idx]);
      test_errors++;
    end
  endfunction

  // --------------------------------------------------------------------------
  // handshake tasks
  // --------------------------------------------------------------------------
  // called right after a rising edge
  task automatic present_request(int idx);
    req_fn  <= tbl_fn[idx];
    req_a   <= tbl_a[idx];
    req_b   <= tbl_b[idx];
    req_val <= 1'b1;
  endtask

  // returns just after the accepting edge
  task automatic wait_for_accept();
    @(negedge clk);
    while (!req_rdy) begin
      @(posedge clk);
      @(negedge clk);
    end
    @(posedge clk);
    req_val <= 1'b0;
  endtask

  // edges from the accepting edge until resp_val is seen
  task automatic measure_latency(output int lat);
    lat = 0;
    @(negedge clk);
    while (!resp_val) begin
      @(posedge clk);
      lat++;
      @(negedge clk);
    end
  endtask

  task automatic hold_and_release(int idx, int stall);
    logic [2*width-1:0] held;
    held = resp_result;
    @(posedge clk);
    // next request arrives early while the response is stalled
    if (idx + 1 < n_tests) begin
      present_request(idx + 1);
    end
    for (int k = 0; k < stall; k++) begin
      @(negedge clk);
      check_held(idx, held);
      @(posedge clk);
    end
    resp_rdy <= 1'b1;
    @(negedge clk);
    check_held(idx, held);
    // transfer edge
    @(posedge clk);
    resp_rdy <= 1'b0;
    @(negedge clk);
    assert (!resp_val && !req_rdy) else begin
      $display("%s: resp_val or req_rdy was high right after the transfer", tbl_name[idx]);
      test_errors++;
    end
  endtask

  // --------------------------------------------------------------------------
  // main sequence
  // --------------------------------------------------------------------------
  initial begin
    imuldiv_fn_e      fn;
    logic [width-1:0] a;
    logic [width-1:0] b;
    int               lat;
    int               stall;
    reset    = 1'b1;
    req_fn   = fn_mul;
    req_a    = '0;
    req_b    = '0;
    req_val  = 1'b0;
    resp_rdy = 1'b0;
    cycles   = 0;
    errors   = 0;
    failed   = 0;
    void'($urandom(32'h75f6));

    // multiply over mixed signs, zero, one, most negative and all ones
    set_entry(0, "mul_pos_neg", fn_mul, 32'h3, 32'hffff_fffb, 64'hffff_ffff_ffff_fff1);
    set_entry(1, "mul_neg_neg", fn_mul, 32'hffff_fff9, 32'hffff_fffa, 64'h2a);
    set_entry(2, "mul_zero", fn_mul, 32'h0, 32'h4d2, 64'h0);
    set_entry(3, "mul_one_m1", fn_mul, 32'h1, 32'hffff_ffff, 64'hffff_ffff_ffff_ffff);
    set_entry(4, "mul_min_min", fn_mul, 32'h8000_0000, 32'h8000_0000, 64'h4000_0000_0000_0000);
    set_entry(5, "mul_min_m1", fn_mul, 32'h8000_0000, 32'hffff_ffff, 64'h0000_0000_8000_0000);
    set_entry(6, "mul_max_min", fn_mul, 32'h7fff_ffff, 32'h8000_0000, 64'hc000_0000_8000_0000);
    set_entry(7, "mulu_ones", fn_mulu, 32'hffff_ffff, 32'hffff_ffff, 64'hffff_fffe_0000_0001);
    set_entry(8, "mulu_ones_2", fn_mulu, 32'hffff_ffff, 32'h2, 64'h0000_0001_ffff_fffe);
    set_entry(9, "mulu_min_2", fn_mulu, 32'h8000_0000, 32'h2, 64'h0000_0001_0000_0000);
    set_entry(10, "mulu_zero", fn_mulu, 32'h1234_5678, 32'h0, 64'h0);
    // divide with the remainder taking the dividend sign
    set_entry(11, "div_pos_pos", fn_div, 32'h14, 32'h3, 64'h0000_0002_0000_0006);
    set_entry(12, "div_neg_pos", fn_div, 32'hffff_ffec, 32'h3, 64'hffff_fffe_ffff_fffa);
    set_entry(13, "div_pos_neg", fn_div, 32'h14, 32'hffff_fffd, 64'h0000_0002_ffff_fffa);
    set_entry(14, "div_neg_neg", fn_div, 32'hffff_ffec, 32'hffff_fffd, 64'hffff_fffe_0000_0006);
    set_entry(15, "div_min_m1", fn_div, 32'h8000_0000, 32'hffff_ffff, 64'h0000_0000_8000_0000);
    set_entry(16, "divu_ones_2", fn_divu, 32'hffff_ffff, 32'h2, 64'h0000_0001_7fff_ffff);
    set_entry(17, "divu_min_ones", fn_divu, 32'h8000_0000, 32'hffff_ffff, 64'h8000_0000_0000_0000);
    // divide by zero
    set_entry(18, "div0_neg", fn_div, 32'hffff_fff9, 32'h0, 64'hffff_fff9_ffff_ffff);
    set_entry(19, "div0_pos", fn_div, 32'h5, 32'h0, 64'h0000_0005_ffff_ffff);
    set_entry(20, "div0_zero", fn_div, 32'h0, 32'h0, 64'h0000_0000_ffff_ffff);
    set_entry(21, "divu0", fn_divu, 32'h1234_5678, 32'h0, 64'h1234_5678_ffff_ffff);

    // random rows with small divisors now and then to reach zero and near zero
    for (int i = n_fixed; i < n_tests; i++) begin
      fn = imuldiv_fn_e'(imuldiv_fn_bits'($urandom_range(0, 3)));
      a  = $urandom();
      b  = ($urandom_range(0, 3) == 0) ? width'($urandom_range(0, 15)) : $urandom();
      set_entry(i, $sformatf("rand_%0d", i - n_fixed), fn, a, b, expected_result(fn, a, b));
    end

    repeat (2) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    assert (req_rdy && !resp_val) else begin
      $display("after reset req_rdy was not high or resp_val was not low");
      errors++;
    end

    @(posedge clk);
    present_request(0);
    for (int i = 0; i < n_tests; i++) begin
      test_errors = 0;
      wait_for_accept();
      measure_latency(lat);
      assert (lat == width + 2) else begin
        $display("Error: %s latency expected %0d actual %0d", tbl_name[i], width + 2, lat);
        test_errors++;
      end
      assert (resp_result === tbl_exp[i]) else begin
        $display("Error: %s expected %h actual %h", tbl_name[i], tbl_exp[i], resp_result);
        test_errors++;
      end
      stall = $urandom_range(0, max_stall);
      hold_and_release(i, stall);
      $display("test %0d %s: %s", i, tbl_name[i], (test_errors == 0) ? "ok" : "failed");
      errors += test_errors;
      if (test_errors != 0) begin
        failed++;
      end
    end

    $display("tests %0d, passed %0d, failed %0d, errors %0d",
             n_tests, n_tests - failed, failed, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
common/imuldiv_pkg.sv
common/op_if.sv
common/fix_if.sv
hdl/imuldiv_operand_unpack.sv
imul/imul_ctrl.sv
imul/imul_dpath.sv
idiv/idiv_restoring.sv
hdl/imuldiv_resp_pack.sv
hdl/imuldiv.sv
sim/imuldiv_tb.sv

/* Makefile */
# Verilator build and run for the iterative multiply/divide unit
# make        build and run the testbench, pass or fail taken from the log
# make lint   lint the RTL top level
# make clean  remove build products and the log

VERILATOR  ?= verilator
FILELIST   ?= project.f
TOP        ?= imuldiv_tb
RTL_TOP    ?= imuldiv
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^>>> PASS$$" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
